// ==== src/cache_pkg.sv ====
//----------------------------------------------------------
// cache-side read request and write-buffer slot types
// addresses are byte addresses, one beat is WORD_BITS wide
//----------------------------------------------------------
`default_nettype none

package cache_pkg;

    localparam int WORD_BITS = 32;

    typedef logic [31:0] addr_t;

    // request as held on the cache read port
    typedef struct packed {
        addr_t      addr;
        logic [2:0] size;  // log2 of bytes, used by dma reads
        logic       dma;
    } rd_req_t;

    // tag part of one write-buffer slot
    typedef struct packed {
        logic  valid;
        addr_t addr;  // line aligned
    } wb_slot_t;

    // clears the word and byte offset bits
    function automatic addr_t line_addr(addr_t a, int offset_width);
        addr_t mask;
        mask = addr_t'((1 << (offset_width + $clog2(WORD_BITS / 8))) - 1);
        return a & ~mask;
    endfunction

endpackage

`default_nettype wire

// ==== src/axi_pkg.sv ====
//----------------------------------------------------------
// AXI read address fields for the memory side
// only INCR bursts with beats of up to 32 bits are issued
//----------------------------------------------------------
`default_nettype none

package axi_pkg;

    localparam int ADDR_BITS = 32;

    // burst type code
    localparam logic [1:0] BURST_INCR = 2'b01;

    // beat size code, log2 of bytes
    localparam logic [2:0] SIZE_WORD = 3'd2;

    typedef struct packed {
        logic [ADDR_BITS-1:0] addr;
        logic [7:0]           len;    // beats minus one
        logic [2:0]           size;
        logic [1:0]           burst;
    } ar_t;

endpackage

`default_nettype wire

// ==== src/wb_entry.sv ====
//----------------------------------------------------------
// one write-buffer slot, load wins over clear
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module wb_entry #(
    parameter int  offset_width = 2,
    localparam int line_bits    = (1 << offset_width) * cache_pkg::WORD_BITS
) (
    input  wire                   clk,
    input  wire                   rstn,
    input  wire                   load,
    input  wire cache_pkg::addr_t load_addr,
    input  wire [line_bits-1:0]   load_line,
    input  wire                   clear,
    input  wire cache_pkg::addr_t query_addr,
    output cache_pkg::wb_slot_t   slot,
    output logic [line_bits-1:0]  line,
    output logic                  match
);

    logic             valid_q;
    cache_pkg::addr_t addr_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (clear) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            addr_q <= cache_pkg::line_addr(load_addr, offset_width);
            line   <= load_line;
        end
    end

    assign slot  = '{valid: valid_q, addr: addr_q};
    assign match = valid_q && (addr_q == cache_pkg::line_addr(query_addr, offset_width));

endmodule

`default_nettype wire

// ==== src/wb_alloc.sv ====
//----------------------------------------------------------
// slot choice for pushed lines, pushes are dropped while full
// full may stay high one cycle after a drain
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module wb_alloc #(
    parameter int  offset_width = 2,
    parameter int  wb_depth     = 4,
    localparam int idx_width    = (wb_depth > 1) ? $clog2(wb_depth) : 1
) (
    input  wire                                 clk,
    input  wire                                 rstn,
    input  wire                                 push,
    input  wire cache_pkg::addr_t               push_addr,
    input  wire cache_pkg::wb_slot_t [wb_depth-1:0] slots,
    output logic [wb_depth-1:0]                 load,
    output logic [idx_width-1:0]                new_slot,
    output logic                                new_valid,
    output logic                                full
);

    logic [wb_depth-1:0]  hit_vec;
    logic [wb_depth-1:0]  free_vec;
    logic [idx_width-1:0] hit_idx;
    logic [idx_width-1:0] free_idx;
    logic                 accept;

    // scan downwards so the lowest index wins
    always_comb begin
        hit_idx  = '0;
        free_idx = '0;
        for (int i = wb_depth - 1; i >= 0; i--) begin
            hit_vec[i]  = slots[i].valid &&
                          (slots[i].addr == cache_pkg::line_addr(push_addr, offset_width));
            free_vec[i] = !slots[i].valid;
            if (hit_vec[i]) begin
                hit_idx = idx_width'(i);
            end
            if (free_vec[i]) begin
                free_idx = idx_width'(i);
            end
        end
    end

    assign accept    = push && !full;
    assign new_slot  = (|hit_vec) ? hit_idx : free_idx;
    assign new_valid = accept && !(|hit_vec);
    assign load      = accept ? (wb_depth'(1) << new_slot) : '0;

    // occupancy after this cycle's load
    always_ff @(posedge clk) begin
        if (!rstn) begin
            full <= 1'b0;
        end else begin
            full <= &(~free_vec | load);
        end
    end

endmodule

`default_nettype wire

// ==== src/wb_select.sv ====
//----------------------------------------------------------
// hit mux for queries, drains slots in allocation order
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module wb_select #(
    parameter int  offset_width = 2,
    parameter int  wb_depth     = 4,
    localparam int line_bits    = (1 << offset_width) * cache_pkg::WORD_BITS,
    localparam int idx_width    = (wb_depth > 1) ? $clog2(wb_depth) : 1
) (
    input  wire                                 clk,
    input  wire                                 rstn,
    input  wire [wb_depth-1:0]                  match,
    input  wire cache_pkg::wb_slot_t [wb_depth-1:0] slots,
    input  wire [wb_depth-1:0][line_bits-1:0]   lines,
    input  wire [idx_width-1:0]                 new_slot,
    input  wire                                 new_valid,
    output logic                                hit,
    output logic [line_bits-1:0]                hit_line,
    output logic                                wr_req,
    output cache_pkg::addr_t                    wr_addr,
    output logic [line_bits-1:0]                wr_line,
    input  wire                                 wr_done,
    output logic [wb_depth-1:0]                 clear
);

    logic [idx_width-1:0] order_q [wb_depth];
    logic [idx_width-1:0] head_q;
    logic [idx_width-1:0] tail_q;
    logic [idx_width:0]   count_q;
    logic [idx_width-1:0] head_slot;
    logic                 pop;

    function automatic logic [idx_width-1:0] next_ptr(logic [idx_width-1:0] p);
        return (p == idx_width'(wb_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    // at most one slot matches
    always_comb begin
        hit_line = '0;
        for (int i = 0; i < wb_depth; i++) begin
            if (match[i]) begin
                hit_line = hit_line | lines[i];
            end
        end
    end

    assign hit = |match;

    // oldest slot on the write port
    assign head_slot = order_q[head_q];
    assign wr_req    = (count_q != '0) && slots[head_slot].valid;
    assign wr_addr   = slots[head_slot].addr;
    assign wr_line   = lines[head_slot];
    assign pop       = wr_req && wr_done;
    assign clear     = pop ? (wb_depth'(1) << head_slot) : '0;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (new_valid) begin
                tail_q <= next_ptr(tail_q);
            end
            if (pop) begin
                head_q <= next_ptr(head_q);
            end
            count_q <= count_q + (idx_width + 1)'(new_valid) - (idx_width + 1)'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (new_valid) begin
            order_q[tail_q] <= new_slot;
        end
    end

endmodule

`default_nettype wire

// ==== src/read_arbiter.sv ====
//----------------------------------------------------------
// one read at a time, write-buffer hit or memory burst
// dma reads always go to memory
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module read_arbiter #(
    parameter int  offset_width = 2,
    localparam int line_bits    = (1 << offset_width) * cache_pkg::WORD_BITS
) (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire                    req_r,
    input  wire cache_pkg::rd_req_t req,
    output logic                   addr_ok,
    input  wire                    rdy,
    output logic                   data_ok,
    output logic [line_bits-1:0]   rd_line,
    output cache_pkg::addr_t       query_addr,
    input  wire                    hit,
    input  wire [line_bits-1:0]    hit_line,
    output logic                   ret_req,
    input  wire                    ret_addr_ok,
    input  wire                    ret_data_ok,
    input  wire [line_bits-1:0]    ret_line
);

    typedef enum logic [2:0] {
        st_idle,
        st_hit_addr,
        st_hit_data,
        st_ret_addr,
        st_ret_data
    } state_t;

    state_t               state_q;
    state_t               state_d;
    logic [line_bits-1:0] line_q;
    logic                 take_hit;

    assign query_addr = req.addr;
    assign take_hit   = req_r && hit && !req.dma;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (take_hit) begin
                    state_d = st_hit_addr;
                end else if (req_r) begin
                    state_d = st_ret_addr;
                end
            end
            st_hit_addr: begin
                state_d = st_hit_data;
            end
            st_hit_data: begin
                if (rdy) begin
                    state_d = st_idle;
                end
            end
            st_ret_addr: begin
                if (ret_addr_ok) begin
                    state_d = st_ret_data;
                end
            end
            st_ret_data: begin
                if (ret_data_ok && rdy) begin
                    state_d = st_idle;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    // keeps the hit line stable if its slot drains meanwhile
    always_ff @(posedge clk) begin
        if (state_q == st_idle && take_hit) begin
            line_q <= hit_line;
        end
    end

    always_comb begin
        addr_ok = 1'b0;
        data_ok = 1'b0;
        ret_req = 1'b0;
        rd_line = '0;
        case (state_q)
            st_hit_addr: begin
                addr_ok = 1'b1;
            end
            st_hit_data: begin
                data_ok = 1'b1;
                rd_line = line_q;
            end
            st_ret_addr: begin
                ret_req = 1'b1;
                addr_ok = ret_addr_ok;
            end
            st_ret_data: begin
                data_ok = ret_data_ok;
                rd_line = ret_line;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/return_buffer.sv ====
//----------------------------------------------------------
// single AXI read burst in flight, line held until rdy
// request must stay stable until ret_addr_ok
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module return_buffer #(
    parameter int  offset_width = 2,
    localparam int words        = 1 << offset_width,
    localparam int line_bits    = words * cache_pkg::WORD_BITS
) (
    input  wire                           clk,
    input  wire                           rstn,
    input  wire                           ret_req,
    input  wire cache_pkg::rd_req_t       req,
    output logic                          ret_addr_ok,
    output logic                          ret_data_ok,
    output logic [line_bits-1:0]          ret_line,
    input  wire                           rdy,
    output axi_pkg::ar_t                  ar,
    output logic                          arvalid,
    input  wire                           arready,
    input  wire [cache_pkg::WORD_BITS-1:0] rdata,
    input  wire                           rlast,
    input  wire                           rvalid,
    output logic                          rready
);

    typedef enum logic [1:0] {
        st_idle,
        st_beats,
        st_hold
    } state_t;

    state_t                  state_q;
    logic [offset_width-1:0] beat_q;

    // full line burst, or one beat of the requested size for dma
    always_comb begin
        ar.burst = axi_pkg::BURST_INCR;
        if (req.dma) begin
            ar.addr = req.addr;
            ar.len  = '0;
            ar.size = req.size;
        end else begin
            ar.addr = cache_pkg::line_addr(req.addr, offset_width);
            ar.len  = 8'(words - 1);
            ar.size = axi_pkg::SIZE_WORD;
        end
    end

    assign arvalid     = (state_q == st_idle) && ret_req;
    assign ret_addr_ok = arvalid && arready;
    assign rready      = (state_q == st_beats);
    assign ret_data_ok = (state_q == st_hold);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= st_idle;
            beat_q  <= '0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (ret_addr_ok) begin
                        state_q <= st_beats;
                        beat_q  <= '0;
                    end
                end
                st_beats: begin
                    if (rvalid) begin
                        beat_q <= beat_q + 1'b1;
                        if (rlast) begin
                            state_q <= st_hold;
                        end
                    end
                end
                st_hold: begin
                    if (rdy) begin
                        state_q <= st_idle;
                    end
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    // cleared at the handshake so a dma word sits alone in lane 0
    always_ff @(posedge clk) begin
        if (ret_addr_ok) begin
            ret_line <= '0;
        end else if (rready && rvalid) begin
            ret_line[beat_q * cache_pkg::WORD_BITS +: cache_pkg::WORD_BITS] <= rdata;
        end
    end

endmodule

`default_nettype wire

// ==== src/mem_read_path.sv ====
//----------------------------------------------------------
// L2 memory-side read path with write buffer
// pushes while full are dropped
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mem_read_path #(
    parameter int  offset_width = 2,
    parameter int  wb_depth     = 4,
    localparam int line_bits    = (1 << offset_width) * cache_pkg::WORD_BITS,
    localparam int idx_width    = (wb_depth > 1) ? $clog2(wb_depth) : 1
) (
    input  wire                            clk,
    input  wire                            rstn,
    input  wire                            req_r,
    input  wire cache_pkg::rd_req_t        req,
    output logic                           addr_ok,
    input  wire                            rdy,
    output logic                           data_ok,
    output logic [line_bits-1:0]           rd_line,
    input  wire                            push,
    input  wire cache_pkg::addr_t          push_addr,
    input  wire [line_bits-1:0]            push_line,
    output logic                           full,
    output logic                           wr_req,
    output cache_pkg::addr_t               wr_addr,
    output logic [line_bits-1:0]           wr_line,
    input  wire                            wr_done,
    output axi_pkg::ar_t                   ar,
    output logic                           arvalid,
    input  wire                            arready,
    input  wire [cache_pkg::WORD_BITS-1:0] rdata,
    input  wire                            rlast,
    input  wire                            rvalid,
    output logic                           rready
);

    cache_pkg::addr_t                   query_addr;
    logic                               hit;
    logic [line_bits-1:0]               hit_line;
    logic                               ret_req;
    logic                               ret_addr_ok;
    logic                               ret_data_ok;
    logic [line_bits-1:0]               ret_line;
    logic [wb_depth-1:0]                load;
    logic [wb_depth-1:0]                clear;
    logic [idx_width-1:0]               new_slot;
    logic                               new_valid;
    wire  [wb_depth-1:0]                match;
    wire  cache_pkg::wb_slot_t [wb_depth-1:0] slots;
    wire  [wb_depth-1:0][line_bits-1:0] lines;

    wb_alloc #(
        .offset_width(offset_width),
        .wb_depth    (wb_depth)
    ) u_wb_alloc (
        .clk      (clk),
        .rstn     (rstn),
        .push     (push),
        .push_addr(push_addr),
        .slots    (slots),
        .load     (load),
        .new_slot (new_slot),
        .new_valid(new_valid),
        .full     (full)
    );

    for (genvar i = 0; i < wb_depth; i++) begin : g_slot
        wb_entry #(
            .offset_width(offset_width)
        ) u_wb_entry (
            .clk       (clk),
            .rstn      (rstn),
            .load      (load[i]),
            .load_addr (push_addr),
            .load_line (push_line),
            .clear     (clear[i]),
            .query_addr(query_addr),
            .slot      (slots[i]),
            .line      (lines[i]),
            .match     (match[i])
        );
    end

    wb_select #(
        .offset_width(offset_width),
        .wb_depth    (wb_depth)
    ) u_wb_select (
        .clk      (clk),
        .rstn     (rstn),
        .match    (match),
        .slots    (slots),
        .lines    (lines),
        .new_slot (new_slot),
        .new_valid(new_valid),
        .hit      (hit),
        .hit_line (hit_line),
        .wr_req   (wr_req),
        .wr_addr  (wr_addr),
        .wr_line  (wr_line),
        .wr_done  (wr_done),
        .clear    (clear)
    );

    read_arbiter #(
        .offset_width(offset_width)
    ) u_read_arbiter (
        .clk        (clk),
        .rstn       (rstn),
        .req_r      (req_r),
        .req        (req),
        .addr_ok    (addr_ok),
        .rdy        (rdy),
        .data_ok    (data_ok),
        .rd_line    (rd_line),
        .query_addr (query_addr),
        .hit        (hit),
        .hit_line   (hit_line),
        .ret_req    (ret_req),
        .ret_addr_ok(ret_addr_ok),
        .ret_data_ok(ret_data_ok),
        .ret_line   (ret_line)
    );

    // rdy doubles as the consume strobe of the held line
    return_buffer #(
        .offset_width(offset_width)
    ) u_return_buffer (
        .clk        (clk),
        .rstn       (rstn),
        .ret_req    (ret_req),
        .req        (req),
        .ret_addr_ok(ret_addr_ok),
        .ret_data_ok(ret_data_ok),
        .ret_line   (ret_line),
        .rdy        (rdy),
        .ar         (ar),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rlast      (rlast),
        .rvalid     (rvalid),
        .rready     (rready)
    );

endmodule

`default_nettype wire

// ==== verif/axi_mem_model.sv ====
//----------------------------------------------------------
// testbench memory for AXI reads and the line write port
// unwritten words read back a fill pattern of their address
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model #(
    parameter int          offset_width = 2,
    parameter logic [31:0] seed_init    = 32'h9d6e1c59,
    localparam int         words        = 1 << offset_width,
    localparam int         line_bits    = words * cache_pkg::WORD_BITS
) (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire                    drain_en,
    input  wire axi_pkg::ar_t      ar,
    input  wire                    arvalid,
    output logic                   arready,
    output logic [31:0]            rdata,
    output logic                   rlast,
    output logic                   rvalid,
    input  wire                    rready,
    input  wire                    wr_req,
    input  wire cache_pkg::addr_t  wr_addr,
    input  wire [line_bits-1:0]    wr_line,
    output logic                   wr_done
);

    logic [31:0]  mem [logic [31:0]];
    axi_pkg::ar_t ar_q;
    logic         busy;
    logic [7:0]   beat;
    logic         taken;
    integer       seed;

    function automatic logic [31:0] mem_fill(logic [31:0] a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h3c6ef372;
    endfunction

    function automatic logic [31:0] read_word(logic [31:0] a);
        logic [31:0] w;
        w = {a[31:2], 2'b00};
        return mem.exists(w) ? mem[w] : mem_fill(w);
    endfunction

    initial begin
        seed    = seed_init;
        arready = 1'b0;
        rdata   = '0;
        rlast   = 1'b0;
        rvalid  = 1'b0;
        wr_done = 1'b0;
    end

    always @(posedge clk) begin
        if (!rstn) begin
            busy  <= 1'b0;
            beat  <= '0;
            taken <= 1'b0;
        end else begin
            taken <= rvalid && rready;
            if (arvalid && arready) begin
                ar_q <= ar;
                busy <= 1'b1;
                beat <= '0;
            end
            if (rvalid && rready) begin
                beat <= beat + 8'd1;
                if (rlast) begin
                    busy <= 1'b0;
                end
            end
            if (wr_req && wr_done) begin
                for (int i = 0; i < words; i++) begin
                    mem[wr_addr + 32'(i * 4)] = wr_line[i * 32 +: 32];
                end
            end
        end
    end

    // random gaps, a beat stays on the bus until taken
    always @(negedge clk) begin
        arready = ($random(seed) & 32'sd1) != 0;
        wr_done = drain_en && wr_req && (($random(seed) & 32'sd3) != 0);
        if (!(rvalid && !taken)) begin
            rvalid = busy && (($random(seed) & 32'sd3) != 0);
            if (busy) begin
                rdata = read_word(ar_q.addr + 32'(beat) * 32'd4);
                rlast = (beat == ar_q.len);
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_mem_read_path.sv ====
//----------------------------------------------------------
// read path testbench against a shadow-memory reference
// reads and pushes never overlap in time
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_mem_read_path;

    localparam int offset_width = 2;
    localparam int wb_depth     = 4;
    localparam int words        = 1 << offset_width;
    localparam int line_bits    = words * cache_pkg::WORD_BITS;
    localparam int n_tests      = 40;

    logic                     clk;
    logic                     rstn;
    logic                     req_r;
    cache_pkg::rd_req_t       req;
    logic                     addr_ok;
    logic                     rdy;
    logic                     data_ok;
    logic [line_bits-1:0]     rd_line;
    logic                     push;
    cache_pkg::addr_t         push_addr;
    logic [line_bits-1:0]     push_line;
    logic                     full;
    logic                     wr_req;
    cache_pkg::addr_t         wr_addr;
    logic [line_bits-1:0]     wr_line;
    logic                     wr_done;
    axi_pkg::ar_t             ar;
    logic                     arvalid;
    logic                     arready;
    logic [31:0]              rdata;
    logic                     rlast;
    logic                     rvalid;
    logic                     rready;
    logic                     drain_en;

    integer                   seed;
    int                       ar_count;
    logic [line_bits-1:0]     exp_line;
    axi_pkg::ar_t             exp_ar;
    logic [line_bits-1:0]     shadow [logic [31:0]];
    logic                     inbuf [logic [31:0]];
    cache_pkg::addr_t         used [$];

    mem_read_path #(
        .offset_width(offset_width),
        .wb_depth    (wb_depth)
    ) u_mem_read_path (
        .clk(clk), .rstn(rstn), .req_r(req_r), .req(req), .addr_ok(addr_ok),
        .rdy(rdy), .data_ok(data_ok), .rd_line(rd_line), .push(push),
        .push_addr(push_addr), .push_line(push_line), .full(full),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_line(wr_line), .wr_done(wr_done),
        .ar(ar), .arvalid(arvalid), .arready(arready), .rdata(rdata),
        .rlast(rlast), .rvalid(rvalid), .rready(rready)
    );

    axi_mem_model #(
        .offset_width(offset_width),
        .seed_init   (32'h9d6e1c59)
    ) u_axi_mem_model (
        .clk(clk), .rstn(rstn), .drain_en(drain_en), .ar(ar), .arvalid(arvalid),
        .arready(arready), .rdata(rdata), .rlast(rlast), .rvalid(rvalid),
        .rready(rready), .wr_req(wr_req), .wr_addr(wr_addr), .wr_line(wr_line),
        .wr_done(wr_done)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] mem_fill(logic [31:0] a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h3c6ef372;
    endfunction

    function automatic logic [31:0] line_of(logic [31:0] a);
        return a & ~32'(words * 4 - 1);
    endfunction

    // shadow line, or the addressed word alone in lane 0 for dma
    function automatic logic [line_bits-1:0] expected_line(cache_pkg::rd_req_t r);
        logic [31:0]          la;
        logic [line_bits-1:0] l;
        int                   w;
        la = line_of(r.addr);
        if (shadow.exists(la)) begin
            l = shadow[la];
        end else begin
            for (int i = 0; i < words; i++) begin
                l[i * 32 +: 32] = mem_fill(la + 32'(i * 4));
            end
        end
        if (r.dma) begin
            w = int'(r.addr[offset_width+1:2]);
            l = line_bits'(l[w * 32 +: 32]);
        end
        return l;
    endfunction

    function automatic logic [line_bits-1:0] rand_line();
        logic [line_bits-1:0] l;
        for (int i = 0; i < words; i++) begin
            l[i * 32 +: 32] = $random(seed);
        end
        return l;
    endfunction

    task automatic stop_fail(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_line(input string name, input logic [line_bits-1:0] exp,
                              input logic [line_bits-1:0] act);
        if (exp !== act) begin
            stop_fail($sformatf("error %s expected %h got %h", name, exp, act));
        end
    endtask

    task automatic check_ar(input string name, input axi_pkg::ar_t exp,
                            input axi_pkg::ar_t act);
        if (exp !== act) begin
            stop_fail($sformatf("error %s expected %h got %h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            stop_fail($sformatf("error %s expected %h got %h", name, exp, act));
        end
    endtask

    task automatic push_once(input logic [31:0] addr, input logic [line_bits-1:0] line);
        while (full) begin
            @(negedge clk);
        end
        push      = 1'b1;
        push_addr = addr;
        push_line = line;
        shadow[line_of(addr)] = line;
        inbuf[line_of(addr)]  = 1'b1;
        used.push_back(addr);
        @(negedge clk);
        push = 1'b0;
        check_bit("full", inbuf.num() == wb_depth, full);
    endtask

    task automatic drain_all();
        drain_en = 1'b1;
        while (wr_req) begin
            @(negedge clk);
        end
        drain_en = 1'b0;
        inbuf.delete();
        // full may lag the last clear by one cycle
        @(negedge clk);
        check_bit("full", 1'b0, full);
    endtask

    task automatic read_once(input cache_pkg::rd_req_t r);
        int   n;
        int   ar_before;
        logic expect_hit;
        logic done;
        expect_hit = inbuf.exists(line_of(r.addr)) && !r.dma;
        exp_line   = expected_line(r);
        if (r.dma) begin
            exp_ar = '{addr: r.addr, len: 8'd0, size: r.size, burst: axi_pkg::BURST_INCR};
        end else begin
            exp_ar = '{addr: line_of(r.addr), len: 8'(words - 1),
                       size: axi_pkg::SIZE_WORD, burst: axi_pkg::BURST_INCR};
        end
        ar_before  = ar_count;
        req_r = 1'b1;
        req   = r;
        n     = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!addr_ok);
        if (expect_hit && n != 2) begin
            stop_fail("addr_ok did not follow req_r by one cycle on a hit");
        end
        if (!expect_hit && !(arvalid && arready)) begin
            stop_fail("addr_ok on a memory read without the AR handshake");
        end
        @(negedge clk);
        req_r = 1'b0;
        n     = 0;
        done  = 1'b0;
        while (!done) begin
            rdy = ($random(seed) & 32'sd3) != 0;
            @(posedge clk);
            n++;
            if (expect_hit && n == 1 && !data_ok) begin
                stop_fail("data_ok did not follow addr_ok on a hit");
            end
            done = data_ok && rdy;
            @(negedge clk);
        end
        rdy = 1'b0;
        if (ar_count - ar_before != (expect_hit ? 0 : 1)) begin
            stop_fail("wrong number of AXI read bursts for one read");
        end
    endtask

    function automatic cache_pkg::rd_req_t make_req(logic [31:0] addr, logic dma);
        cache_pkg::rd_req_t r;
        r.addr = addr;
        r.dma  = dma;
        r.size = dma ? 3'($unsigned($random(seed)) % 3) : 3'd2;
        return r;
    endfunction

    // compares every returned line and every AR handshake
    always @(posedge clk) begin
        if (rstn) begin
            if (data_ok && rdy) begin
                check_line("rd_line", exp_line, rd_line);
            end
            if (arvalid && arready) begin
                check_ar("ar", exp_ar, ar);
                ar_count++;
            end
        end
    end

    initial begin
        #(n_tests * 200 * 40);
        $display("timeout, the DUT stopped answering");
        $display("sim failed");
        $fatal(1, "watchdog");
    end

    initial begin
        logic [31:0] a;
        logic [31:0] x;
        logic        use_dma;
        clk       = 1'b0;
        rstn      = 1'b0;
        seed      = 32'h9d6e1c59;
        ar_count  = 0;
        req_r     = 1'b0;
        req       = '0;
        rdy       = 1'b0;
        push      = 1'b0;
        push_addr = '0;
        push_line = '0;
        drain_en  = 1'b0;
        exp_line  = '0;
        exp_ar    = '0;
        repeat (4) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        check_bit("full", 1'b0, full);
        check_bit("wr_req", 1'b0, wr_req);

        // misses from memory
        for (int i = 0; i < 4; i++) begin
            read_once(make_req($random(seed), 1'b0));
        end
        // hits from the write buffer
        for (int i = 0; i < 2; i++) begin
            a = $random(seed);
            push_once(a, rand_line());
            read_once(make_req(a, 1'b0));
        end
        // same line twice keeps one slot
        x = $random(seed);
        push_once(x, rand_line());
        push_once(x + 32'd4, rand_line());
        read_once(make_req(x, 1'b0));
        // fourth slot fills the buffer
        push_once($random(seed), rand_line());
        drain_all();
        for (int i = 0; i < used.size(); i++) begin
            read_once(make_req(used[i], 1'b0));
        end
        // uncached single beats
        for (int i = 0; i < 4; i++) begin
            read_once(make_req($random(seed), 1'b1));
            read_once(make_req(used[i], 1'b1));
        end
        // mixed reads with some lines buffered
        push_once($random(seed), rand_line());
        push_once($random(seed), rand_line());
        for (int i = 0; i < 6; i++) begin
            a = used[$unsigned($random(seed)) % used.size()];
            // dma bypasses the write buffer and would see stale memory
            use_dma = (($random(seed) & 32'sd1) != 0) && !inbuf.exists(line_of(a));
            read_once(make_req(a, use_dma));
        end
        drain_all();
        for (int i = used.size() - 2; i < used.size(); i++) begin
            read_once(make_req(used[i], 1'b0));
        end
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
src/cache_pkg.sv
src/axi_pkg.sv
src/wb_entry.sv
src/wb_alloc.sv
src/wb_select.sv
src/read_arbiter.sv
src/return_buffer.sv
src/mem_read_path.sv
verif/axi_mem_model.sv
verif/tb_mem_read_path.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_mem_read_path
FILELIST  := src.f
FLAGS     := --binary --timing -j 0
OBJ_DIR   := obj_dir

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
